/* apb_dual_timer.f */
logic/timer_pkg.sv
logic/apb_timer_decode.sv
logic/timer_downcounter.sv
logic/timer_channel.sv
logic/timer_readback.sv
logic/apb_dual_timer.sv
dv/apb_dual_timer_props.sv
dv/apb_dual_timer_tb.sv

/* Makefile */
# Verilator simulation of the APB dual timer
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= apb_dual_timer_tb
LOG       ?= sim.log
FILELIST  ?= apb_dual_timer.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "Result: PASSED" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* dv/apb_dual_timer_tb.sv */
// --------------------
// APB dual timer testbench
// Table of APB writes, read checks and interrupt waits
// with cycle-exact latency checks on the timer channels
// --------------------
`timescale 1ns/100ps
`default_nettype none

module apb_dual_timer_tb;

  import timer_pkg::*;

  localparam int NUM_TIMERS = 2;

  // Row operations
  localparam int OP_WR   = 0;
  localparam int OP_RD   = 1;
  localparam int OP_RDLE = 2;
  localparam int OP_RDGE = 3;
  localparam int OP_INT  = 4;
  localparam int OP_WAIT = 5;
  localparam int OP_IDLE = 6;

  // Compare kinds
  localparam int CMP_EQ = 0;
  localparam int CMP_LE = 1;
  localparam int CMP_GE = 2;

  localparam apb_data_t ALL = 32'hFFFF_FFFF;

  // One stimulus row
  // data holds write data, read mask, wait timeout or idle cycles
  // addr holds the interrupt bit for a wait
  typedef struct {
    int        op;
    apb_addr_t addr;
    apb_data_t data;
    apb_data_t exp;
    string     name;
  } row_t;

  logic                  PCLK;
  logic                  PRESETn;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  apb_addr_t             paddr;
  apb_data_t             pwdata;
  apb_data_t             prdata;
  logic [NUM_TIMERS-1:0] timint;
  logic                  timintc;

  row_t        rows[$];
  int unsigned cycle = 0;
  int unsigned wr_edge = 0;

  apb_dual_timer #(
    .NUM_TIMERS (NUM_TIMERS)
  ) uut (
    .PCLK    (PCLK),
    .PRESETn (PRESETn),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .timint  (timint),
    .timintc (timintc)
  );

  // 40 ns clock
  initial
  begin
    PCLK = 1'b0;
    forever #20 PCLK = ~PCLK;
  end

  // Edge counter for latency measurement
  always @(posedge PCLK)
    cycle <= cycle + 1;

  // --------------------
  // Failure and compare
  task automatic end_with_failure();
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped at the first failure");
  endtask

  task automatic check_value(input string name, input int kind, input apb_data_t exp,
                             input apb_data_t act);
    logic  ok;
    string rel;
    case (kind)
      CMP_LE:
      begin
        ok  = (act <= exp);
        rel = "at most ";
      end
      CMP_GE:
      begin
        ok  = (act >= exp);
        rel = "at least ";
      end
      default:
      begin
        ok  = (act == exp);
        rel = "";
      end
    endcase
    if (!ok)
    begin
      $display("Error %s: expected %s0x%08h, actual 0x%08h", name, rel, exp, act);
      end_with_failure();
    end
  endtask

  // --------------------
  // APB transfers, zero wait states
  task automatic apb_write(input apb_addr_t addr, input apb_data_t data);
    @(posedge PCLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b1;
    paddr   <= addr;
    pwdata  <= data;
    // DUT takes the write at this edge, counter still shows the edge before
    @(posedge PCLK);
    wr_edge = cycle + 1;
    penable <= 1'b1;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
    pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data);
    @(posedge PCLK);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= 1'b0;
    paddr   <= addr;
    @(posedge PCLK);
    penable <= 1'b1;
    // Sampled mid access phase
    @(negedge PCLK);
    data = prdata;
    @(posedge PCLK);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  // Interrupt wait, bounded
  task automatic wait_irq(input int idx, input int limit, input string name);
    int n;
    n = 0;
    @(negedge PCLK);
    while (!timint[idx])
    begin
      if (n >= limit)
      begin
        $display("Timeout: timint[%0d] did not rise within %0d cycles in %s", idx, limit, name);
        end_with_failure();
      end
      n++;
      @(negedge PCLK);
    end
  endtask

  function automatic void add_row(input int op, input apb_addr_t addr, input apb_data_t data,
                                  input apb_data_t exp, input string name);
    row_t r;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.exp  = exp;
    r.name = name;
    rows.push_back(r);
  endfunction

  // --------------------
  // Stimulus table
  function automatic void build_table();
    // Reset values, both channels
    add_row(OP_RD, 12'h000, ALL, 32'h0, "ch0 LOAD reset");
    add_row(OP_RD, 12'h004, ALL, 32'hFFFF_FFFF, "ch0 VALUE reset");
    add_row(OP_RD, 12'h008, ALL, 32'h20, "ch0 CONTROL reset");
    add_row(OP_RD, 12'h010, ALL, 32'h0, "ch0 RIS reset");
    add_row(OP_RD, 12'h014, ALL, 32'h0, "ch0 MIS reset");
    add_row(OP_RD, 12'h020, ALL, 32'h0, "ch1 LOAD reset");
    add_row(OP_RD, 12'h024, ALL, 32'hFFFF_FFFF, "ch1 VALUE reset");
    add_row(OP_RD, 12'h028, ALL, 32'h20, "ch1 CONTROL reset");
    add_row(OP_RD, 12'h030, ALL, 32'h0, "ch1 RIS reset");
    add_row(OP_RD, 12'h034, ALL, 32'h0, "ch1 MIS reset");
    // One-shot of 5 at prescale 1, interrupt 5 cycles after the load
    add_row(OP_WR, 12'h008, 32'hA3, 0, "ch0 oneshot control");
    add_row(OP_WR, 12'h000, 32'd5, 0, "ch0 oneshot load");
    add_row(OP_WAIT, 12'd0, 32'd40, 32'd5, "ch0 oneshot latency");
    add_row(OP_INT, 12'h000, 32'h2, 32'h0, "ch1 irq idle");
    add_row(OP_IDLE, 12'h000, 32'd8, 0, "ch0 oneshot hold");
    add_row(OP_RD, 12'h004, ALL, 32'h0, "ch0 VALUE stopped");
    add_row(OP_RD, 12'h004, ALL, 32'h0, "ch0 VALUE still stopped");
    // Mask and clear on the stopped channel
    add_row(OP_RD, 12'h010, ALL, 32'h1, "ch0 RIS set");
    add_row(OP_RD, 12'h014, ALL, 32'h1, "ch0 MIS set");
    add_row(OP_WR, 12'h008, 32'h83, 0, "ch0 irq disable");
    add_row(OP_RD, 12'h014, ALL, 32'h0, "ch0 MIS masked");
    add_row(OP_INT, 12'h000, 32'h1, 32'h0, "ch0 timint masked");
    add_row(OP_RD, 12'h010, ALL, 32'h1, "ch0 RIS kept");
    add_row(OP_WR, 12'h00C, 32'h1, 0, "ch0 intclr");
    add_row(OP_RD, 12'h010, ALL, 32'h0, "ch0 RIS cleared");
    add_row(OP_WR, 12'h000, 32'h0, 0, "ch0 zero load");
    add_row(OP_RD, 12'h000, ALL, 32'd5, "ch0 LOAD kept");
    // Periodic with a background reload of 3
    add_row(OP_WR, 12'h028, 32'hE2, 0, "ch1 periodic control");
    add_row(OP_WR, 12'h020, 32'd40, 0, "ch1 periodic load");
    add_row(OP_WR, 12'h038, 32'd3, 0, "ch1 bgload");
    add_row(OP_RD, 12'h020, ALL, 32'd3, "ch1 LOAD after bgload");
    add_row(OP_RD, 12'h038, ALL, 32'd3, "ch1 BGLOAD readback");
    add_row(OP_WAIT, 12'd1, 32'd100, 32'd0, "ch1 first periodic irq");
    add_row(OP_WR, 12'h02C, 32'h1, 0, "ch1 intclr");
    // Next zero of the 3 period is still one cycle away here
    add_row(OP_INT, 12'h000, 32'h2, 32'h0, "ch1 irq cleared");
    add_row(OP_WAIT, 12'd1, 32'd50, 32'd0, "ch1 second periodic irq");
    add_row(OP_RDLE, 12'h024, ALL, 32'd3, "ch1 VALUE within period a");
    add_row(OP_RDLE, 12'h024, ALL, 32'd3, "ch1 VALUE within period b");
    add_row(OP_RDLE, 12'h024, ALL, 32'd3, "ch1 VALUE within period c");
    add_row(OP_WR, 12'h028, 32'h20, 0, "ch1 stop");
    add_row(OP_WR, 12'h02C, 32'h1, 0, "ch1 intclr after stop");
    add_row(OP_INT, 12'h000, 32'h3, 32'h0, "both irqs idle");
    // 16-bit free-running wrap, upper half holds
    add_row(OP_WR, 12'h008, 32'hA0, 0, "ch0 wrap control");
    add_row(OP_WR, 12'h000, 32'h0001_0002, 0, "ch0 wrap load");
    add_row(OP_WAIT, 12'd0, 32'd20, 32'd2, "ch0 wrap latency");
    add_row(OP_RD, 12'h004, 32'hFFFF_0000, 32'h0001_0000, "ch0 upper half a");
    add_row(OP_RDGE, 12'h004, 32'h0000_FFFF, 32'hFF01, "ch0 low half wrapped a");
    add_row(OP_RD, 12'h004, 32'hFFFF_0000, 32'h0001_0000, "ch0 upper half b");
    add_row(OP_RDGE, 12'h004, 32'h0000_FFFF, 32'hFF01, "ch0 low half wrapped b");
    add_row(OP_WR, 12'h008, 32'h20, 0, "ch0 stop");
    add_row(OP_WR, 12'h00C, 32'h1, 0, "ch0 intclr after wrap");
    // Prescale 16, one-shot of 2 gives 32 cycles
    add_row(OP_WR, 12'h020, 32'd2, 0, "ch1 preload while idle");
    add_row(OP_WR, 12'h028, 32'hA7, 0, "ch1 prescale control");
    add_row(OP_WR, 12'h020, 32'd2, 0, "ch1 prescale load");
    add_row(OP_WAIT, 12'd1, 32'd100, 32'd32, "ch1 prescale latency");
    add_row(OP_RD, 12'h024, ALL, 32'h0, "ch1 VALUE after prescale");
    add_row(OP_RD, 12'h030, ALL, 32'h1, "ch1 RIS after prescale");
  endfunction

  // --------------------
  // Main sequence
  initial
  begin
    row_t      r;
    apb_data_t rd;
    PRESETn = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    build_table();
    repeat (5) @(posedge PCLK);
    PRESETn <= 1'b1;
    foreach (rows[i])
    begin
      r = rows[i];
      case (r.op)
        OP_WR:
          apb_write(r.addr, r.data);
        OP_RD, OP_RDLE, OP_RDGE:
        begin
          apb_read(r.addr, rd);
          check_value(r.name, (r.op == OP_RDLE) ? CMP_LE : (r.op == OP_RDGE) ? CMP_GE : CMP_EQ,
                      r.exp, rd & r.data);
        end
        OP_INT:
        begin
          @(negedge PCLK);
          check_value(r.name, CMP_EQ, r.exp, apb_data_t'(timint) & r.data);
          // Combined interrupt is the OR of every channel
          if (&r.data[NUM_TIMERS-1:0])
            check_value({r.name, " timintc"}, CMP_EQ, apb_data_t'(r.exp != 0),
                        apb_data_t'(timintc));
        end
        OP_WAIT:
        begin
          wait_irq(int'(r.addr), int'(r.data), r.name);
          check_value({r.name, " timintc"}, CMP_EQ, 32'h1, apb_data_t'(timintc));
          // Zero means any arrival time is fine
          if (r.exp != 0)
            check_value(r.name, CMP_EQ, r.exp, cycle - wr_edge);
        end
        OP_IDLE:
          repeat (r.data) @(posedge PCLK);
        default:
        begin
          $display("Unknown table operation %0d in row %s", r.op, r.name);
          end_with_failure();
        end
      endcase
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

/* dv/apb_dual_timer_props.sv */
// --------------------
// APB dual timer properties
// Interrupt and read data rules on the top-level ports
// --------------------
`timescale 1ns/100ps
`default_nettype none

module apb_dual_timer_props #(
  parameter int NUM_TIMERS = 2
) (
  input wire                       PCLK,
  input wire                       PRESETn,
  input wire                       psel,
  input wire timer_pkg::apb_data_t prdata,
  input wire [NUM_TIMERS-1:0]      timint,
  input wire                       timintc
);

  // Combined interrupt follows the vector
  timintc_is_or: assert property (@(posedge PCLK) disable iff (!PRESETn)
    timintc == |timint)
  else $error("timintc differs from the OR of timint");

  // First cycle out of reset has no interrupt
  irq_low_after_reset: assert property (@(posedge PCLK)
    (!$past(PRESETn) && PRESETn) |-> (timint == '0))
  else $error("timint not zero in the cycle after reset");

  // Idle bus reads zero
  prdata_zero_idle: assert property (@(posedge PCLK) disable iff (!PRESETn)
    !psel |-> (prdata == '0))
  else $error("prdata not zero while psel is low");

endmodule

bind apb_dual_timer apb_dual_timer_props #(
  .NUM_TIMERS (NUM_TIMERS)
) u_props (
  .PCLK    (PCLK),
  .PRESETn (PRESETn),
  .psel    (psel),
  .prdata  (prdata),
  .timint  (timint),
  .timintc (timintc)
);

`default_nettype wire

/* logic/apb_dual_timer.sv */
// --------------------
// APB dual timer top level
// Address decode, NUM_TIMERS timer channels and the read mux
// --------------------
`timescale 1ns/100ps
`default_nettype none

module apb_dual_timer #(
  parameter int NUM_TIMERS = 2
) (
  input  wire                       PCLK,
  input  wire                       PRESETn,
  input  wire                       psel,
  input  wire                       penable,
  input  wire                       pwrite,
  input  wire timer_pkg::apb_addr_t paddr,
  input  wire timer_pkg::apb_data_t pwdata,
  output timer_pkg::apb_data_t      prdata,
  output logic [NUM_TIMERS-1:0]     timint,
  output logic                      timintc
);

  import timer_pkg::*;

  localparam int CHAN_W = (NUM_TIMERS > 1) ? $clog2(NUM_TIMERS) : 1;

  // Decode outputs
  logic [NUM_TIMERS-1:0] wr_load;
  logic [NUM_TIMERS-1:0] wr_bgload;
  logic [NUM_TIMERS-1:0] wr_ctrl;
  logic [NUM_TIMERS-1:0] wr_intclr;
  logic [CHAN_W-1:0]     rd_chan;
  reg_offset_t           rd_offset;
  logic                  rd_en;

  // Channel outputs
  timer_count_t          load_period [NUM_TIMERS];
  timer_count_t          count [NUM_TIMERS];
  timer_ctrl_t           ctrl [NUM_TIMERS];
  logic [NUM_TIMERS-1:0] ris;
  logic [NUM_TIMERS-1:0] mis;

  apb_timer_decode #(
    .NUM_TIMERS (NUM_TIMERS)
  ) u_decode (
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .wr_load   (wr_load),
    .wr_bgload (wr_bgload),
    .wr_ctrl   (wr_ctrl),
    .wr_intclr (wr_intclr),
    .rd_chan   (rd_chan),
    .rd_offset (rd_offset),
    .rd_en     (rd_en)
  );

  // --------------------
  // Timer channels
  for (genvar i = 0; i < NUM_TIMERS; i++)
  begin : gen_chan
    timer_channel u_chan (
      .PCLK        (PCLK),
      .PRESETn     (PRESETn),
      .wr_load     (wr_load[i]),
      .wr_bgload   (wr_bgload[i]),
      .wr_ctrl     (wr_ctrl[i]),
      .wr_intclr   (wr_intclr[i]),
      .pwdata      (pwdata),
      .load_period (load_period[i]),
      .count       (count[i]),
      .ctrl        (ctrl[i]),
      .ris         (ris[i]),
      .mis         (mis[i])
    );
  end

  timer_readback #(
    .NUM_TIMERS (NUM_TIMERS)
  ) u_readback (
    .rd_chan     (rd_chan),
    .rd_offset   (rd_offset),
    .rd_en       (rd_en),
    .load_period (load_period),
    .count       (count),
    .ctrl        (ctrl),
    .ris         (ris),
    .mis         (mis),
    .prdata      (prdata),
    .timint      (timint),
    .timintc     (timintc)
  );

endmodule

`default_nettype wire

/* logic/timer_readback.sv */
// --------------------
// Timer read mux and interrupt outputs
// Returns the addressed channel register and
// drives the interrupt vector and its OR
// --------------------
`timescale 1ns/100ps
`default_nettype none

module timer_readback #(
  parameter int NUM_TIMERS = 2,
  localparam int CHAN_W = (NUM_TIMERS > 1) ? $clog2(NUM_TIMERS) : 1
) (
  input  wire [CHAN_W-1:0]             rd_chan,
  input  wire timer_pkg::reg_offset_t  rd_offset,
  input  wire                          rd_en,
  input  wire timer_pkg::timer_count_t load_period [NUM_TIMERS],
  input  wire timer_pkg::timer_count_t count [NUM_TIMERS],
  input  wire timer_pkg::timer_ctrl_t  ctrl [NUM_TIMERS],
  input  wire [NUM_TIMERS-1:0]         ris,
  input  wire [NUM_TIMERS-1:0]         mis,
  output timer_pkg::apb_data_t         prdata,
  output logic [NUM_TIMERS-1:0]        timint,
  output logic                         timintc
);

  import timer_pkg::*;

  // --------------------
  // Read data mux
  // Unmapped offsets and idle bus read zero
  always_comb
  begin
    prdata = '0;
    if (rd_en)
    begin
      case (rd_offset)
        // Both load addresses return the next reload value
        OFS_LOAD,
        OFS_BGLOAD:  prdata = load_period[rd_chan];
        OFS_VALUE:   prdata = count[rd_chan];
        OFS_CONTROL: prdata[7:0] = ctrl[rd_chan];
        OFS_RIS:     prdata[0] = ris[rd_chan];
        OFS_MIS:     prdata[0] = mis[rd_chan];
        default:     prdata = '0;
      endcase
    end
  end

  // --------------------
  // Interrupt outputs
  assign timint  = mis;
  assign timintc = |mis;

endmodule

`default_nettype wire

/* logic/timer_channel.sv */
// --------------------
// One timer channel
// Control, load period and raw interrupt registers
// around the prescaled down-counter
// --------------------
`timescale 1ns/100ps
`default_nettype none

module timer_channel (
  input  wire                       PCLK,
  input  wire                       PRESETn,
  input  wire                       wr_load,
  input  wire                       wr_bgload,
  input  wire                       wr_ctrl,
  input  wire                       wr_intclr,
  input  wire timer_pkg::apb_data_t pwdata,
  output timer_pkg::timer_count_t   load_period,
  output timer_pkg::timer_count_t   count,
  output timer_pkg::timer_ctrl_t    ctrl,
  output logic                      ris,
  output logic                      mis
);

  import timer_pkg::*;

  logic data_nz;
  logic load_go;
  logic period_go;
  logic zero_event;

  // --------------------
  // Write qualification
  // Zero data to LOAD or BGLOAD is dropped
  assign data_nz = |pwdata;

  // LOAD restarts the counter, BGLOAD only changes the period
  assign load_go   = wr_load & data_nz;
  assign period_go = (wr_load | wr_bgload) & data_nz;

  // --------------------
  // Control and period registers
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      ctrl        <= CTRL_RESET;
      load_period <= LOAD_RESET;
    end
    else
    begin
      // Unused bit 4 is forced low
      if (wr_ctrl)
        ctrl <= pwdata[7:0] & CTRL_WR_MASK;
      if (period_go)
        load_period <= pwdata;
    end
  end

  // --------------------
  // Raw interrupt
  // Set on the zero event, a clear in the same cycle wins
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
      ris <= 1'b0;
    else if (wr_intclr)
      ris <= 1'b0;
    else if (zero_event)
      ris <= 1'b1;
  end

  // Masked interrupt
  assign mis = ris & ctrl[CTRL_INTEN_BIT];

  // Counter core
  timer_downcounter u_counter (
    .PCLK       (PCLK),
    .PRESETn    (PRESETn),
    .load       (load_go),
    .load_val   (pwdata),
    .period     (load_period),
    .ctrl       (ctrl),
    .count      (count),
    .zero_event (zero_event)
  );

endmodule

`default_nettype wire

/* logic/timer_downcounter.sv */
// --------------------
// Prescaled timer down-counter
// 16 or 32-bit decrement with periodic reload,
// free-running wrap and one-shot stop at zero
// --------------------
`timescale 1ns/100ps
`default_nettype none

module timer_downcounter (
  input  wire                          PCLK,
  input  wire                          PRESETn,
  input  wire                          load,
  input  wire timer_pkg::timer_count_t load_val,
  input  wire timer_pkg::timer_count_t period,
  input  wire timer_pkg::timer_ctrl_t  ctrl,
  output timer_pkg::timer_count_t      count,
  output logic                         zero_event
);

  import timer_pkg::*;

  // Control fields
  logic       en;
  logic       periodic;
  logic       size32;
  logic       one_shot;
  logic [1:0] pre;

  prescale_t    prescale_q;
  prescale_t    prescale_nxt;
  logic         pre_sel;
  logic         tick;
  logic         stopped;
  logic         cnt_upd;
  logic [15:0]  dec_low;
  logic [15:0]  dec_high;
  timer_count_t count_nxt;
  logic         zero_q;
  logic         zero_nxt;

  assign en       = ctrl[CTRL_EN_BIT];
  assign periodic = ctrl[CTRL_PERIODIC_BIT];
  assign size32   = ctrl[CTRL_SIZE_BIT];
  assign one_shot = ctrl[CTRL_ONESHOT_BIT];
  assign pre      = ctrl[CTRL_PRE_MSB:CTRL_PRE_LSB];

  // --------------------
  // Prescaler
  // Cleared by a load so the first period is a full one
  assign prescale_nxt = load ? '0 : (en ? prescale_q - 1'b1 : prescale_q);

  // Tick select, 11 behaves like 00
  always_comb
  begin
    case (pre)
      2'b01:   pre_sel = (prescale_q[3:0] == 4'h1);
      2'b10:   pre_sel = (prescale_q == 8'h01);
      default: pre_sel = 1'b1;
    endcase
  end

  assign tick = en & pre_sel;

  // One-shot holds at zero until reloaded or mode cleared
  assign stopped = one_shot & zero_q;

  assign cnt_upd = load | (tick & ~stopped);

  // --------------------
  // Split decrement
  // Upper half borrows only in 32-bit mode
  assign dec_low  = count[15:0] - 16'd1;
  assign dec_high = (size32 && (count[15:0] == 16'h0000)) ?
                    count[31:16] - 16'd1 : count[31:16];

  // Next count
  // Decrementing past zero gives the free-running wrap
  always_comb
  begin
    if (load)
      count_nxt = load_val;
    else if (tick && !stopped)
    begin
      if (zero_q && periodic)
        count_nxt = period;
      else
        count_nxt = {dec_high, dec_low};
    end
    else
      count_nxt = count;
  end

  // Zero is judged on the low half in 16-bit mode
  assign zero_nxt = size32 ? (count_nxt == '0) : (count_nxt[15:0] == 16'h0000);

  // Only the transition into zero counts as an event
  assign zero_event = cnt_upd & zero_nxt & ~zero_q;

  // --------------------
  // State registers
  // Count resets to all ones so no interrupt fires out of reset
  always_ff @(posedge PCLK)
  begin
    if (!PRESETn)
    begin
      prescale_q <= '0;
      count      <= COUNT_RESET;
      zero_q     <= 1'b0;
    end
    else
    begin
      prescale_q <= prescale_nxt;
      count      <= count_nxt;
      zero_q     <= zero_nxt;
    end
  end

endmodule

`default_nettype wire

/* logic/apb_timer_decode.sv */
// --------------------
// APB address decode for the timer channels
// Setup-phase writes become one-cycle per-channel strobes,
// reads become a channel index and a word offset
// --------------------
`timescale 1ns/100ps
`default_nettype none

module apb_timer_decode #(
  parameter int NUM_TIMERS = 2,
  localparam int CHAN_W = (NUM_TIMERS > 1) ? $clog2(NUM_TIMERS) : 1
) (
  input  wire                      psel,
  input  wire                      penable,
  input  wire                      pwrite,
  input  wire timer_pkg::apb_addr_t paddr,
  output logic [NUM_TIMERS-1:0]    wr_load,
  output logic [NUM_TIMERS-1:0]    wr_bgload,
  output logic [NUM_TIMERS-1:0]    wr_ctrl,
  output logic [NUM_TIMERS-1:0]    wr_intclr,
  output logic [CHAN_W-1:0]        rd_chan,
  output timer_pkg::reg_offset_t   rd_offset,
  output logic                     rd_en
);

  import timer_pkg::*;

  // Width of the channel field above the channel stride
  localparam int CHAN_FIELD_W = $bits(apb_addr_t) - CHAN_STRIDE_BITS;

  logic [CHAN_FIELD_W-1:0] chan_field;
  logic                    chan_ok;
  logic                    wr_setup;

  // --------------------
  // Address split
  assign chan_field = paddr[$bits(apb_addr_t)-1:CHAN_STRIDE_BITS];
  assign rd_offset  = paddr[CHAN_STRIDE_BITS-1:2];
  assign rd_chan    = chan_field[CHAN_W-1:0];

  // Channels above NUM_TIMERS are unmapped
  assign chan_ok = (chan_field < NUM_TIMERS);

  // Zero-wait write, acts at the end of the setup phase
  assign wr_setup = psel & ~penable & pwrite & chan_ok;

  // Read select stays valid through the access phase
  assign rd_en = psel & ~pwrite & chan_ok;

  // --------------------
  // One strobe per channel and register
  always_comb
  begin
    wr_load   = '0;
    wr_bgload = '0;
    wr_ctrl   = '0;
    wr_intclr = '0;
    for (int i = 0; i < NUM_TIMERS; i++)
    begin
      if (wr_setup && (chan_field == i))
      begin
        wr_load[i]   = (rd_offset == OFS_LOAD);
        wr_bgload[i] = (rd_offset == OFS_BGLOAD);
        wr_ctrl[i]   = (rd_offset == OFS_CONTROL);
        wr_intclr[i] = (rd_offset == OFS_INTCLR);
      end
    end
  end

endmodule

`default_nettype wire

/* logic/timer_pkg.sv */
// --------------------
// Timer package
// Bus widths, register word offsets, control bit fields and
// reset values shared by the APB dual timer blocks
// --------------------
`default_nettype none

package timer_pkg;

  // Bus and counter widths
  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [31:0] timer_count_t;
  typedef logic [7:0]  timer_ctrl_t;
  typedef logic [2:0]  reg_offset_t;
  typedef logic [7:0]  prescale_t;

  // --------------------
  // Register word offsets inside one channel
  localparam reg_offset_t OFS_LOAD    = 3'd0;
  localparam reg_offset_t OFS_VALUE   = 3'd1;
  localparam reg_offset_t OFS_CONTROL = 3'd2;
  localparam reg_offset_t OFS_INTCLR  = 3'd3;
  localparam reg_offset_t OFS_RIS     = 3'd4;
  localparam reg_offset_t OFS_MIS     = 3'd5;
  localparam reg_offset_t OFS_BGLOAD  = 3'd6;

  // 32 bytes per channel
  localparam int CHAN_STRIDE_BITS = 5;

  // --------------------
  // Control register fields
  localparam int CTRL_EN_BIT       = 7;
  localparam int CTRL_PERIODIC_BIT = 6;
  localparam int CTRL_INTEN_BIT    = 5;
  localparam int CTRL_PRE_MSB      = 3;
  localparam int CTRL_PRE_LSB      = 2;
  localparam int CTRL_SIZE_BIT     = 1;
  localparam int CTRL_ONESHOT_BIT  = 0;

  // Bit 4 is not implemented and reads zero
  localparam timer_ctrl_t CTRL_WR_MASK = 8'hEF;

  // Reset values
  localparam timer_ctrl_t  CTRL_RESET  = 8'h20;
  localparam timer_count_t COUNT_RESET = 32'hFFFF_FFFF;
  localparam timer_count_t LOAD_RESET  = 32'h0000_0000;

endpackage

`default_nettype wire
